// File: Bender.yml
package:
  name: fm_synth

sources:
  - files:
      - logic/fm_pkg.sv
      - logic/voice_cfg_if.sv
      - logic/voice_out_if.sv
      - logic/fm_reg_file.sv
      - logic/fm_voice.sv
      - logic/fm_mixer.sv
      - logic/fm_synth.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_fm_synth.sv

// File: list.f
logic/fm_pkg.sv
logic/voice_cfg_if.sv
logic/voice_out_if.sv
logic/fm_reg_file.sv
logic/fm_voice.sv
logic/fm_mixer.sv
logic/fm_synth.sv
testbench/tb_clock_gen.sv
testbench/tb_fm_synth.sv

// File: logic/fm_mixer.sv
module fm_mixer #(
    parameter int NUM_VOICES = 4
) (
    input  logic                               clk,
    input  logic                               rst,
    voice_out_if.sink                          voice_in [NUM_VOICES],
    output logic                               sample_valid,
    output logic signed [fm_pkg::OUT_WIDTH-1:0] sample_l,
    output logic signed [fm_pkg::OUT_WIDTH-1:0] sample_r
);
    import fm_pkg::*;

    logic signed [OUT_WIDTH-1:0] ext    [NUM_VOICES]; // sign-extended samples
    logic        [NUM_VOICES-1:0] vld;
    logic        [NUM_VOICES-1:0] pan_l;
    logic        [NUM_VOICES-1:0] pan_r;
    logic signed [OUT_WIDTH-1:0] sum_l;
    logic signed [OUT_WIDTH-1:0] sum_r;

    for (genvar i = 0; i < NUM_VOICES; i++) begin : g_tap
        assign ext[i]   = {{(OUT_WIDTH - SAMPLE_WIDTH){voice_in[i].sample[SAMPLE_WIDTH-1]}},
                           voice_in[i].sample};
        assign vld[i]   = voice_in[i].valid;
        assign pan_l[i] = voice_in[i].pan_l;
        assign pan_r[i] = voice_in[i].pan_r;
    end

    // 4 x 12 bit fits in 16, no saturation
    always_comb begin
        sum_l = '0;
        sum_r = '0;
        for (int v = 0; v < NUM_VOICES; v++) begin
            if (pan_l[v]) sum_l = sum_l + ext[v];
            if (pan_r[v]) sum_r = sum_r + ext[v];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sample_valid <= 1'b0;
            sample_l     <= '0;
            sample_r     <= '0;
        end else begin
            sample_valid <= vld[0]; // voices run in lockstep
            if (vld[0]) begin
                sample_l <= sum_l;
                sample_r <= sum_r;
            end
        end
    end

    voices_in_step: assert property (
        @(posedge clk) disable iff (rst) (vld == '0) || (&vld)
    );

endmodule

// File: logic/fm_pkg.sv
package fm_pkg;

    localparam int DATA_WIDTH    = 8;  // wishbone data byte
    localparam int FNUM_WIDTH    = 10; // frequency number
    localparam int FNUM_HI_WIDTH = FNUM_WIDTH - DATA_WIDTH; // fnum bits in key-block reg
    localparam int BLOCK_WIDTH   = 3;  // octave shift
    localparam int PHASE_WIDTH   = 18; // phase accumulator
    localparam int SAMPLE_WIDTH  = 12; // signed voice sample
    localparam int OUT_WIDTH     = 16; // signed mixed sample
    localparam int ATTEN_WIDTH   = 4;  // arithmetic shift amount
    localparam int REG_SEL_WIDTH = 2;  // register within a voice

    // register select codes, code 3 unused
    localparam logic [REG_SEL_WIDTH-1:0] REG_FNUM_LO    = 2'd0;
    localparam logic [REG_SEL_WIDTH-1:0] REG_KEY_BLOCK  = 2'd1;
    localparam logic [REG_SEL_WIDTH-1:0] REG_WAVE_LEVEL = 2'd2;

    typedef enum logic [1:0] {
        WAVE_SQUARE = 2'd0,
        WAVE_SAW    = 2'd1,
        WAVE_TRI    = 2'd2,
        WAVE_OFF    = 2'd3
    } wave_t;

    typedef struct packed {
        logic [1:0]               unused;  // reads back as written
        logic                     key_on;  // bit 5
        logic [BLOCK_WIDTH-1:0]   block;   // bits 4:2
        logic [FNUM_HI_WIDTH-1:0] fnum_hi; // bits 1:0
    } key_block_t;

    typedef struct packed {
        logic                   pan_l; // bit 7
        logic                   pan_r; // bit 6
        wave_t                  wave;  // bits 5:4
        logic [ATTEN_WIDTH-1:0] atten; // bits 3:0
    } wave_level_t;

    // one bus byte, two register layouts
    typedef union packed {
        logic [DATA_WIDTH-1:0] raw;
        key_block_t            kb;
        wave_level_t           wl;
    } reg_word_t;

    // bits of the voice index within the bus address
    function automatic int voice_idx_width(int num_voices);
        return (num_voices > 1) ? $clog2(num_voices) : 1;
    endfunction

    function automatic int adr_width(int num_voices);
        return REG_SEL_WIDTH + voice_idx_width(num_voices);
    endfunction

endpackage

// File: logic/fm_reg_file.sv
module fm_reg_file #(
    parameter int NUM_VOICES = 4,
    parameter int SAMPLE_DIV = 64
) (
    input  logic                                         clk,
    input  logic                                         rst,
    input  logic                                         wb_cyc,
    input  logic                                         wb_stb,
    input  logic                                         wb_we,
    input  logic [fm_pkg::adr_width(NUM_VOICES)-1:0]     wb_adr,
    input  logic [fm_pkg::DATA_WIDTH-1:0]                wb_dat_w,
    output logic [fm_pkg::DATA_WIDTH-1:0]                wb_dat_r,
    output logic                                         wb_ack,
    voice_cfg_if.source                                  cfg [NUM_VOICES]
);
    import fm_pkg::*;

    localparam int VIDX_WIDTH = voice_idx_width(NUM_VOICES);
    localparam int CNT_WIDTH  = (SAMPLE_DIV > 1) ? $clog2(SAMPLE_DIV) : 1;

    logic [VIDX_WIDTH-1:0]    voice_idx;
    logic [REG_SEL_WIDTH-1:0] reg_sel;
    logic                     idx_ok;     // address hits a built voice
    logic                     access;     // first cycle of a bus cycle
    logic [DATA_WIDTH-1:0]    rd_data;
    logic [DATA_WIDTH-1:0]    fnum_lo    [NUM_VOICES];
    reg_word_t                key_block  [NUM_VOICES];
    reg_word_t                wave_level [NUM_VOICES];
    logic [CNT_WIDTH-1:0]     div_cnt;    // clocks within sample period
    logic                     tick;

    assign reg_sel   = wb_adr[REG_SEL_WIDTH-1:0];
    assign voice_idx = wb_adr[REG_SEL_WIDTH +: VIDX_WIDTH];
    assign idx_ok    = int'(voice_idx) < NUM_VOICES;
    assign access    = wb_cyc && wb_stb && !wb_ack; // no second ack while stb held

    always_comb begin
        rd_data = '0; // select 3 and stray voices read zero
        if (idx_ok) begin
            case (reg_sel)
                REG_FNUM_LO:    rd_data = fnum_lo[voice_idx];
                REG_KEY_BLOCK:  rd_data = key_block[voice_idx].raw;
                REG_WAVE_LEVEL: rd_data = wave_level[voice_idx].raw;
                default:        rd_data = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack <= 1'b0;
            for (int v = 0; v < NUM_VOICES; v++) begin
                fnum_lo[v]        <= '0;
                key_block[v].raw  <= '0;
                wave_level[v].raw <= '0;
            end
        end else begin
            wb_ack <= access; // single-cycle ack
            if (access && wb_we && idx_ok) begin // write lands with ack
                case (reg_sel)
                    REG_FNUM_LO:    fnum_lo[voice_idx]        <= wb_dat_w;
                    REG_KEY_BLOCK:  key_block[voice_idx].raw  <= wb_dat_w;
                    REG_WAVE_LEVEL: wave_level[voice_idx].raw <= wb_dat_w;
                    default: ; // unused select
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        wb_dat_r <= (access && !wb_we) ? rd_data : '0; // valid alongside ack
    end

    // sample period divider, tick on last count
    always_ff @(posedge clk) begin
        if (rst) begin
            div_cnt <= '0;
            tick    <= 1'b0;
        end else begin
            tick <= (div_cnt == CNT_WIDTH'(SAMPLE_DIV - 1));
            if (div_cnt == CNT_WIDTH'(SAMPLE_DIV - 1)) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    for (genvar i = 0; i < NUM_VOICES; i++) begin : g_cfg
        assign cfg[i].fnum   = {key_block[i].kb.fnum_hi, fnum_lo[i]};
        assign cfg[i].block  = key_block[i].kb.block;
        assign cfg[i].key_on = key_block[i].kb.key_on;
        assign cfg[i].wave   = wave_level[i].wl.wave;
        assign cfg[i].atten  = wave_level[i].wl.atten;
        assign cfg[i].pan_l  = wave_level[i].wl.pan_l;
        assign cfg[i].pan_r  = wave_level[i].wl.pan_r;
        assign cfg[i].tick   = tick; // same strobe to every voice
    end

    ack_single_cycle: assert property (
        @(posedge clk) disable iff (rst) wb_ack |=> !wb_ack
    );

    tick_single_cycle: assert property (
        @(posedge clk) disable iff (rst) tick |=> !tick
    );

endmodule

// File: logic/fm_synth.sv
module fm_synth #(
    parameter  int NUM_VOICES = 4,
    parameter  int SAMPLE_DIV = 64,
    localparam int ADR_WIDTH  = fm_pkg::adr_width(NUM_VOICES)
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                wb_cyc,
    input  logic                                wb_stb,
    input  logic                                wb_we,
    input  logic [ADR_WIDTH-1:0]                wb_adr,   // {voice, reg select}
    input  logic [fm_pkg::DATA_WIDTH-1:0]       wb_dat_w,
    output logic [fm_pkg::DATA_WIDTH-1:0]       wb_dat_r,
    output logic                                wb_ack,
    output logic                                sample_valid,
    output logic signed [fm_pkg::OUT_WIDTH-1:0] sample_l,
    output logic signed [fm_pkg::OUT_WIDTH-1:0] sample_r
);

    voice_cfg_if cfg_bus [NUM_VOICES] (); // reg file to voices
    voice_out_if out_bus [NUM_VOICES] (); // voices to mixer

    fm_reg_file #(
        .NUM_VOICES (NUM_VOICES),
        .SAMPLE_DIV (SAMPLE_DIV)
    ) u_reg_file (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .cfg      (cfg_bus)
    );

    for (genvar i = 0; i < NUM_VOICES; i++) begin : g_voice
        fm_voice u_voice (
            .clk (clk),
            .rst (rst),
            .cfg (cfg_bus[i]),
            .out (out_bus[i])
        );
    end

    fm_mixer #(
        .NUM_VOICES (NUM_VOICES)
    ) u_mixer (
        .clk          (clk),
        .rst          (rst),
        .voice_in     (out_bus),
        .sample_valid (sample_valid), // two cycles after tick
        .sample_l     (sample_l),
        .sample_r     (sample_r)
    );

endmodule

// File: logic/fm_voice.sv
module fm_voice (
    input  logic       clk,
    input  logic       rst,
    voice_cfg_if.sink  cfg,
    voice_out_if.source out
);
    import fm_pkg::*;

    localparam int MSB = SAMPLE_WIDTH - 1;
    localparam logic signed [SAMPLE_WIDTH-1:0] SQ_HIGH = {1'b0, {MSB{1'b1}}}; // +2047
    localparam logic signed [SAMPLE_WIDTH-1:0] SQ_LOW  = {1'b1, {MSB{1'b0}}}; // -2048

    logic        [PHASE_WIDTH-1:0]  phase;
    logic        [PHASE_WIDTH-1:0]  step;       // fnum << block
    logic        [PHASE_WIDTH-1:0]  phase_next;
    logic        [SAMPLE_WIDTH-1:0] t;          // top bits of new phase
    logic        [SAMPLE_WIDTH-1:0] tri_fold;
    logic signed [SAMPLE_WIDTH-1:0] wave_val;
    logic signed [SAMPLE_WIDTH-1:0] atten_val;

    assign step       = PHASE_WIDTH'(cfg.fnum) << cfg.block; // max 17 bits, no overflow
    assign phase_next = cfg.key_on ? phase + step : '0;      // wraps mod 2^PHASE_WIDTH
    assign t          = phase_next[PHASE_WIDTH-1 -: SAMPLE_WIDTH];

    // double the slope, mirror the upper half
    assign tri_fold = t[MSB] ? ~{t[MSB-1:0], 1'b0} : {t[MSB-1:0], 1'b0};

    always_comb begin
        wave_val = '0; // key-off and WAVE_OFF stay silent
        if (cfg.key_on) begin
            case (cfg.wave)
                WAVE_SQUARE: wave_val = t[MSB] ? SQ_LOW : SQ_HIGH;
                WAVE_SAW:    wave_val = {~t[MSB], t[MSB-1:0]};        // offset binary to signed
                WAVE_TRI:    wave_val = {~tri_fold[MSB], tri_fold[MSB-1:0]};
                default:     wave_val = '0;
            endcase
        end
    end

    assign atten_val = wave_val >>> cfg.atten; // keeps sign

    always_ff @(posedge clk) begin
        if (rst) begin
            phase     <= '0;
            out.valid <= 1'b0;
        end else begin
            out.valid <= cfg.tick;  // one cycle per sample period
            if (cfg.tick) begin
                phase <= phase_next; // zero while keyed off
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cfg.tick) begin
            out.sample <= atten_val;
            out.pan_l  <= cfg.pan_l;
            out.pan_r  <= cfg.pan_r;
        end
    end

    valid_after_tick: assert property (
        @(posedge clk) disable iff (rst) out.valid |-> $past(cfg.tick)
    );

endmodule

// File: logic/voice_cfg_if.sv
interface voice_cfg_if;
    import fm_pkg::*;

    logic [FNUM_WIDTH-1:0]  fnum;   // 10-bit frequency number
    logic [BLOCK_WIDTH-1:0] block;  // octave, left shift of fnum
    logic                   key_on; // gates the voice
    wave_t                  wave;
    logic [ATTEN_WIDTH-1:0] atten;  // >>> amount
    logic                   pan_l;
    logic                   pan_r;
    logic                   tick;   // shared sample strobe

    modport source (
        output fnum,
        output block,
        output key_on,
        output wave,
        output atten,
        output pan_l,
        output pan_r,
        output tick
    );

    modport sink (
        input fnum,
        input block,
        input key_on,
        input wave,
        input atten,
        input pan_l,
        input pan_r,
        input tick
    );

endinterface

// File: logic/voice_out_if.sv
interface voice_out_if;
    import fm_pkg::*;

    logic signed [SAMPLE_WIDTH-1:0] sample; // attenuated waveform
    logic                           valid;  // one cycle after tick
    logic                           pan_l;  // route to left sum
    logic                           pan_r;  // route to right sum

    modport source (
        output sample,
        output valid,
        output pan_l,
        output pan_r
    );

    modport sink (
        input sample,
        input valid,
        input pan_l,
        input pan_r
    );

endinterface

// File: testbench/tb_clock_gen.sv
module tb_clock_gen #(
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // 20 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0; // released between edges
    end

endmodule

// File: testbench/tb_fm_synth.sv
module tb_fm_synth;
    timeunit 1ns;
    timeprecision 1ps;
    import fm_pkg::*;

    localparam int NUM_VOICES     = 4;
    localparam int SAMPLE_DIV     = 64;
    localparam int ADR_WIDTH      = REG_SEL_WIDTH + $clog2(NUM_VOICES);
    localparam int TIMEOUT_CYCLES = 40 * SAMPLE_DIV + 200; // whole sequence is about 31 periods

    logic                        clk;
    logic                        rst;
    logic                        wb_cyc;
    logic                        wb_stb;
    logic                        wb_we;
    logic [ADR_WIDTH-1:0]        wb_adr;
    logic [7:0]                  wb_dat_w;
    logic [7:0]                  wb_dat_r;
    logic                        wb_ack;
    logic                        sample_valid;
    logic signed [OUT_WIDTH-1:0] sample_l;
    logic signed [OUT_WIDTH-1:0] sample_r;

    logic [7:0]             mirror  [NUM_VOICES][4]; // last value written per register
    logic [PHASE_WIDTH-1:0] m_phase [NUM_VOICES];    // model phase accumulators
    int                     exp_l = 0;
    int                     exp_r = 0;
    logic [7:0]             exp_rd;                  // expected read data
    int                     since_rst = 0;           // clocks since reset release
    logic [15:0]            lfsr = 16'd6850;

    tb_clock_gen #(.RESET_CYCLES(16)) u_clk_gen (.clk(clk), .rst(rst));

    fm_synth #(.NUM_VOICES(NUM_VOICES), .SAMPLE_DIV(SAMPLE_DIV)) u_dut (.*);

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1);
    endtask

    // fibonacci lfsr on x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
    function automatic int unsigned draw_bits(input int n);
        int unsigned val;
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            val  = (val << 1) | lfsr[0];
        end
        return val;
    endfunction

    function automatic void step_model();
        logic [7:0]              kb;
        logic [7:0]              wl;
        logic [SAMPLE_WIDTH-1:0] t;
        int                      s;
        int                      d;
        exp_l = 0;
        exp_r = 0;
        for (int v = 0; v < NUM_VOICES; v++) begin
            kb = mirror[v][REG_KEY_BLOCK];
            wl = mirror[v][REG_WAVE_LEVEL];
            if (kb[5]) m_phase[v] += PHASE_WIDTH'({kb[1:0], mirror[v][REG_FNUM_LO]}) << kb[4:2];
            else m_phase[v] = '0; // key-off restarts from zero
            t = m_phase[v][PHASE_WIDTH-1 -: SAMPLE_WIDTH];
            case (wl[5:4])
                2'd0: s = t[SAMPLE_WIDTH-1] ? -2048 : 2047;
                2'd1: s = int'(t) - 2048;           // ramp centred on zero
                2'd2: begin
                    d = (int'(t) * 2) % 4096;
                    if (t[SAMPLE_WIDTH-1]) d = 4095 - d; // falling half
                    s = d - 2048;
                end
                default: s = 0;
            endcase
            if (!kb[5]) s = 0;
            s = s >>> wl[3:0];
            if (wl[7]) exp_l += s;
            if (wl[6]) exp_r += s;
        end
    endfunction

    task automatic bus_cycle(input logic we, input int v, input int sel, input logic [7:0] data);
        int waited;
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = ADR_WIDTH'((v << REG_SEL_WIDTH) | sel);
        wb_dat_w = data;
        waited   = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!wb_ack && waited < 4);
        if (!wb_ack) stop_on_error($sformatf("bus never acked voice %0d register %0d", v, sel));
        @(negedge clk); // stb stays up one cycle past ack and draws no second ack
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic reg_write(input int v, input int sel, input logic [7:0] data);
        bus_cycle(1'b1, v, sel, data);
        if (sel != 3) mirror[v][sel] = data; // select 3 stores nothing
    endtask

    task automatic reg_read(input int v, input int sel);
        exp_rd = (sel == 3) ? 8'h00 : mirror[v][sel];
        bus_cycle(1'b0, v, sel, 8'h00);
    endtask

    task automatic set_voice(input int v, input logic key, input logic [FNUM_WIDTH-1:0] fnum,
                             input logic [BLOCK_WIDTH-1:0] block, input wave_t wave,
                             input logic [ATTEN_WIDTH-1:0] atten, input logic pl, input logic pr);
        reg_write(v, REG_FNUM_LO, fnum[7:0]);
        reg_write(v, REG_KEY_BLOCK, {2'b00, key, block, fnum[9:8]});
        reg_write(v, REG_WAVE_LEVEL, {pl, pr, wave, atten});
    endtask

    // returns mid sample_valid cycle, well clear of the next tick
    task automatic wait_samples(input int n);
        repeat (n) begin
            do @(negedge clk); while (!sample_valid);
        end
    endtask

    always @(negedge clk) begin
        if (rst) begin
            for (int v = 0; v < NUM_VOICES; v++) begin
                m_phase[v] = '0;
                for (int s = 0; s < 4; s++) mirror[v][s] = '0;
            end
        end else if (sample_valid) begin
            step_model(); // expected sums for the sample now on the outputs
        end
    end

    always @(posedge clk) begin
        since_rst <= rst ? 0 : since_rst + 1;
        if (since_rst >= TIMEOUT_CYCLES)
            stop_on_error($sformatf("timeout, test sequence still running after %0d cycles",
                                    TIMEOUT_CYCLES));
    end

    // first tick SAMPLE_DIV clocks after release and sample_valid two later
    sample_cadence: assert property (@(posedge clk) disable iff (rst)
        sample_valid == (since_rst >= SAMPLE_DIV + 2 && (since_rst - 2) % SAMPLE_DIV == 0))
        else stop_on_error($sformatf("Fail at %0t: sample_valid is %0b, expected %0b", $time,
                           $sampled(sample_valid), !$sampled(sample_valid)));

    left_sum: assert property (@(posedge clk) disable iff (rst)
        sample_valid |-> int'(sample_l) == exp_l)
        else stop_on_error($sformatf("Fail at %0t: sample_l is %0d, expected %0d", $time,
                           $sampled(sample_l), $sampled(exp_l)));

    right_sum: assert property (@(posedge clk) disable iff (rst)
        sample_valid |-> int'(sample_r) == exp_r)
        else stop_on_error($sformatf("Fail at %0t: sample_r is %0d, expected %0d", $time,
                           $sampled(sample_r), $sampled(exp_r)));

    ack_after_request: assert property (@(posedge clk) disable iff (rst)
        wb_cyc && wb_stb && !wb_ack |=> wb_ack)
        else stop_on_error($sformatf("Fail at %0t: wb_ack is 0, expected 1", $time));

    ack_one_cycle: assert property (@(posedge clk) disable iff (rst)
        wb_ack |=> !wb_ack)
        else stop_on_error($sformatf("Fail at %0t: wb_ack is 1, expected 0", $time));

    ack_needs_request: assert property (@(posedge clk) disable iff (rst)
        wb_ack |-> $past(wb_cyc && wb_stb))
        else stop_on_error($sformatf("Fail at %0t: wb_ack is 1 without a request, expected 0",
                           $time));

    readback: assert property (@(posedge clk) disable iff (rst)
        wb_ack && !$past(wb_we) |-> wb_dat_r == exp_rd)
        else stop_on_error($sformatf("Fail at %0t: wb_dat_r is %h, expected %h", $time,
                           $sampled(wb_dat_r), $sampled(exp_rd)));

    initial begin : stimulus
        int v;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        exp_rd   = '0;
        wait_samples(1);
        for (int i = 0; i < NUM_VOICES; i++) begin // random bytes with the key bit cleared
            reg_write(i, REG_FNUM_LO, 8'(draw_bits(8)));
            reg_write(i, REG_KEY_BLOCK, 8'(draw_bits(8)) & 8'hdf);
            reg_write(i, REG_WAVE_LEVEL, 8'(draw_bits(8)));
        end
        for (int i = 0; i < NUM_VOICES; i++) begin
            for (int s = 0; s < 4; s++) reg_read(i, s);
            reg_write(i, 3, 8'hff); // unused select
            for (int s = 0; s < 4; s++) reg_read(i, s);
        end
        wait_samples(1);
        for (int i = 0; i < NUM_VOICES; i++) begin
            set_voice(i, 1'b0, 10'h3ff, 3'd7, WAVE_SAW, 4'd0, 1, 1);
        end
        wait_samples(2);
        set_voice(0, 1'b1, 10'h155, 3'd5, WAVE_OFF, 4'd0, 1'b1, 1'b1); // running but silent
        wait_samples(2);
        set_voice(0, 1'b1, 10'h155, 3'd5, WAVE_SQUARE, 4'd0, 1'b1, 1'b1);
        wait_samples(2);
        set_voice(0, 1'b0, 10'h155, 3'd5, WAVE_SQUARE, 4'd0, 1'b1, 1'b1);
        wait_samples(1);
        set_voice(0, 1'b1, 10'h155, 3'd5, WAVE_SAW, 4'd0, 1'b1, 1'b1); // restarts at zero
        wait_samples(2);
        for (int w = 0; w < 3; w++) begin // square then saw then tri on two voices each
            for (int k = 0; k < 2; k++) begin
                v = (2 * w + k) % NUM_VOICES;
                for (int i = 0; i < NUM_VOICES; i++) reg_write(i, REG_KEY_BLOCK, 8'h00);
                set_voice(v, 1'b1, 10'(draw_bits(10)), 3'(draw_bits(3)), wave_t'(w), 4'd0, 1, 1);
                wait_samples(2);
            end
        end
        for (int round = 0; round < 2; round++) begin // pan 00, 01, 10, 11 by voice
            for (int i = 0; i < NUM_VOICES; i++) begin
                set_voice(i, 1'b1, 10'(draw_bits(10)), 3'(draw_bits(3)),
                          wave_t'(draw_bits(2) % 3), 4'(draw_bits(4)), i[1], i[0]);
            end
            wait_samples(3);
        end
        repeat (2) @(negedge clk); // last sample checked at the next edge
        $display("All tests passed");
        $finish;
    end

endmodule
